// File: source/tcdm_ooo_pkg.sv
// ******************************
// tcdm ooo package: default sizes, latencies
// and the op / latency-class enums
// ******************************

`default_nettype none

package tcdm_ooo_pkg;

  // default sizes, overridden only through the top level parameters
  parameter int unsigned DEFAULT_NB_CHAN  = 4;    // initiator channels
  parameter int unsigned DEFAULT_DW       = 32;   // data width in bits
  parameter int unsigned DEFAULT_AW       = 12;   // byte address width
  parameter int unsigned DEFAULT_NB_WORDS = 512;  // bank depth in words

  // response latency, counted in edges after the grant edge
  parameter int unsigned FAST_LAT = 1;  // lower half of the bank
  parameter int unsigned SLOW_LAT = 3;  // upper half of the bank

  // operation decoded from wen (TCDM wen is active low)
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // latency class of an access, picks the delay line insertion point
  typedef enum logic {
    LAT_FAST = 1'b0,
    LAT_SLOW = 1'b1
  } lat_class_e;

endpackage : tcdm_ooo_pkg

`default_nettype wire

// File: source/tcdm_ooo_mux.sv
// ******************************
// tcdm ooo mux: N-to-1 arbiter, tags requests
// with an id and routes responses back by id
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_mux #(
  parameter int unsigned NB_CHAN = 4,
  parameter int unsigned DW      = 32,
  parameter int unsigned AW      = 12,
  // derived, not meant to be overridden
  parameter int unsigned IW      = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear,           // sync clear of rr counter

  input  logic                            priority_force,
  input  logic [NB_CHAN-1:0][IW-1:0]      priority_list,   // entry 0 is highest

  // initiator side
  input  logic [NB_CHAN-1:0]              in_req,
  output logic [NB_CHAN-1:0]              in_gnt,
  input  logic [NB_CHAN-1:0][AW-1:0]      in_add,
  input  logic [NB_CHAN-1:0]              in_wen,
  input  logic [NB_CHAN-1:0][DW-1:0]      in_data,
  input  logic [NB_CHAN-1:0][DW/8-1:0]    in_be,
  output logic [NB_CHAN-1:0]              in_r_valid,
  output logic [NB_CHAN-1:0][DW-1:0]      in_r_data,
  output logic [NB_CHAN-1:0]              in_r_opc,

  // memory side
  output logic                            mem_req,
  input  logic                            mem_gnt,
  output logic [AW-1:0]                   mem_add,
  output logic                            mem_wen,
  output logic [DW-1:0]                   mem_data,
  output logic [DW/8-1:0]                 mem_be,
  output logic [IW-1:0]                   mem_id,          // winner channel number

  input  logic                            resp_valid,
  input  logic [DW-1:0]                   resp_data,
  input  logic                            resp_opc,
  input  logic [IW-1:0]                   resp_id          // channel the response belongs to
);

  logic [IW-1:0]              rr_counter_q;
  logic [NB_CHAN-1:0][IW-1:0] rank_chan;     // channel holding each rank, rank 0 first
  logic [IW-1:0]              winner;
  logic                       xfer;

  assign xfer = mem_req & mem_gnt;  // a transfer happens on this edge

  // round-robin counter, moves only when something is actually granted
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear) begin
      rr_counter_q <= '0;
    end else if (xfer) begin
      if (rr_counter_q == IW'(NB_CHAN-1))
        rr_counter_q <= '0;  // wrap
      else
        rr_counter_q <= rr_counter_q + IW'(1);
    end
  end

  // rank list: rotated by the counter, or taken from outside when forced
  always_comb begin
    for (int unsigned r = 0; r < NB_CHAN; r++) begin
      if (priority_force)
        rank_chan[r] = priority_list[r];
      else
        rank_chan[r] = IW'((int'(rr_counter_q) + r) % NB_CHAN);
    end
  end

  // winner-takes-all, scanned from lowest rank up so the best requester wins
  always_comb begin
    winner = rr_counter_q;  // nobody requesting: counter value, whose req is low
    for (int r = NB_CHAN-1; r >= 0; r--) begin
      if (in_req[rank_chan[r]])
        winner = rank_chan[r];
    end
  end

  // forward the winner's request fields
  assign mem_req  = in_req[winner];
  assign mem_add  = in_add[winner];
  assign mem_wen  = in_wen[winner];
  assign mem_data = in_data[winner];
  assign mem_be   = in_be[winner];
  assign mem_id   = winner;  // id tag travels with the access

  // grant only to the winner, response valid only to the id owner
  always_comb begin
    for (int unsigned ch = 0; ch < NB_CHAN; ch++) begin
      in_gnt[ch]     = (winner == IW'(ch)) ? (in_req[ch] & mem_gnt) : 1'b0;
      in_r_valid[ch] = (resp_id == IW'(ch)) ? resp_valid : 1'b0;
      in_r_data[ch]  = resp_data;  // broadcast
      in_r_opc[ch]   = resp_opc;   // broadcast
    end
  end

endmodule : tcdm_ooo_mux

`default_nettype wire

// File: source/tcdm_mem_bank.sv
// ******************************
// tcdm mem bank: request decode and
// byte-enabled array access
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_mem_bank #(
  parameter int unsigned DW       = 32,
  parameter int unsigned AW       = 12,
  parameter int unsigned NB_WORDS = 512,
  parameter int unsigned NB_CHAN  = 4,
  // derived, not meant to be overridden
  parameter int unsigned IW       = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       mem_req,
  input  logic                       mem_gnt,
  input  logic [AW-1:0]              mem_add,
  input  logic                       mem_wen,     // low means write
  input  logic [DW-1:0]              mem_data,
  input  logic [DW/8-1:0]            mem_be,
  input  logic [IW-1:0]              mem_id,

  output logic                       acc_valid,   // access happens on this edge
  output tcdm_ooo_pkg::mem_op_e      acc_op,
  output tcdm_ooo_pkg::lat_class_e   acc_lat,     // valid before the grant too
  output logic [DW-1:0]              acc_data,
  output logic                       acc_err,
  output logic [IW-1:0]              acc_id
);

  localparam int unsigned NB_BYTES = DW / 8;
  localparam int unsigned OFFW     = (NB_BYTES > 1) ? $clog2(NB_BYTES) : 0;
  localparam int unsigned IDXW     = AW - OFFW;                 // word index bits
  localparam int unsigned WADDRW   = (NB_WORDS > 1) ? $clog2(NB_WORDS) : 1;

  logic [DW-1:0]     mem_q [NB_WORDS];  // storage, contents undefined until written

  logic [IDXW-1:0]   word_idx;
  logic [31:0]       word_idx_ext;      // widened so the range compare never wraps
  logic [WADDRW-1:0] word_addr;
  logic              in_range;
  logic              do_write;

  // decode
  assign word_idx     = mem_add[AW-1:OFFW];  // byte address / (DW/8)
  assign word_idx_ext = 32'(word_idx);
  assign word_addr    = word_idx[WADDRW-1:0];
  assign in_range     = (word_idx_ext < NB_WORDS);

  assign acc_op  = mem_wen ? tcdm_ooo_pkg::MEM_READ : tcdm_ooo_pkg::MEM_WRITE;
  assign acc_lat = (word_idx_ext >= NB_WORDS / 2) ? tcdm_ooo_pkg::LAT_SLOW
                                                  : tcdm_ooo_pkg::LAT_FAST;
  assign acc_err = ~in_range;   // index at or beyond bank depth
  assign acc_id  = mem_id;      // id passes straight through

  assign acc_valid = mem_req & mem_gnt;

  // execute
  // writes land only on a real in-range transfer, never while held in reset
  assign do_write = acc_valid & rst_ni & in_range & (acc_op == tcdm_ooo_pkg::MEM_WRITE);

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int unsigned b = 0; b < NB_BYTES; b++) begin
        if (mem_be[b])
          mem_q[word_addr][8*b +: 8] <= mem_data[8*b +: 8];  // byte lane b
      end
    end
  end

  // read is combinational, so it sees the word before this edge's write
  always_comb begin
    acc_data = '0;  // writes and errored accesses carry no data
    if (in_range && acc_op == tcdm_ooo_pkg::MEM_READ)
      acc_data = mem_q[word_addr];
  end

endmodule : tcdm_mem_bank

`default_nettype wire

// File: source/tcdm_resp_scheduler.sv
// ******************************
// tcdm resp scheduler: fast/slow delay line
// and grant back-pressure
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_resp_scheduler #(
  parameter int unsigned DW      = 32,
  parameter int unsigned NB_CHAN = 4,
  // derived, not meant to be overridden
  parameter int unsigned IW      = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       mem_req,
  input  tcdm_ooo_pkg::lat_class_e   mem_add_slow,  // class of the pending access
  output logic                       mem_gnt,

  input  logic                       acc_valid,
  input  tcdm_ooo_pkg::mem_op_e      acc_op,
  input  tcdm_ooo_pkg::lat_class_e   acc_lat,
  input  logic [DW-1:0]              acc_data,
  input  logic                       acc_err,
  input  logic [IW-1:0]              acc_id,

  output logic                       resp_valid,
  output logic [DW-1:0]              resp_data,
  output logic                       resp_opc,
  output logic [IW-1:0]              resp_id
);

  localparam int unsigned NB_STAGES  = tcdm_ooo_pkg::SLOW_LAT;
  // fast entries skip ahead so they need FAST_LAT edges to the output
  localparam int unsigned FAST_STAGE = tcdm_ooo_pkg::SLOW_LAT - tcdm_ooo_pkg::FAST_LAT;

  logic          stg_valid_q [NB_STAGES];
  logic [DW-1:0] stg_data_q  [NB_STAGES];
  logic          stg_err_q   [NB_STAGES];
  logic [IW-1:0] stg_id_q    [NB_STAGES];

  logic          ins_fast;
  logic          ins_slow;
  logic [DW-1:0] ins_data;

  // a fast access would collide with whatever moves into the fast stage
  assign mem_gnt = mem_req &
                   ~((mem_add_slow == tcdm_ooo_pkg::LAT_FAST) & stg_valid_q[FAST_STAGE-1]);

  assign ins_fast = acc_valid & (acc_lat == tcdm_ooo_pkg::LAT_FAST);
  assign ins_slow = acc_valid & (acc_lat == tcdm_ooo_pkg::LAT_SLOW);
  assign ins_data = (acc_op == tcdm_ooo_pkg::MEM_WRITE) ? '0 : acc_data;  // writes answer zero

  // occupancy of the delay line plus output stage
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned s = 0; s < NB_STAGES; s++)
        stg_valid_q[s] <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      stg_valid_q[0] <= ins_slow;  // slow entry point
      for (int unsigned s = 1; s < NB_STAGES; s++) begin
        if (s == FAST_STAGE)
          stg_valid_q[s] <= stg_valid_q[s-1] | ins_fast;  // never both, see mem_gnt
        else
          stg_valid_q[s] <= stg_valid_q[s-1];
      end
      resp_valid <= stg_valid_q[NB_STAGES-1];
    end
  end

  // payload shifts along with the valid bits
  always_ff @(posedge clk_i) begin
    stg_data_q[0] <= ins_data;
    stg_err_q[0]  <= acc_err;
    stg_id_q[0]   <= acc_id;
    for (int unsigned s = 1; s < NB_STAGES; s++) begin
      if (s == FAST_STAGE && ins_fast) begin
        stg_data_q[s] <= ins_data;
        stg_err_q[s]  <= acc_err;
        stg_id_q[s]   <= acc_id;
      end else begin
        stg_data_q[s] <= stg_data_q[s-1];
        stg_err_q[s]  <= stg_err_q[s-1];
        stg_id_q[s]   <= stg_id_q[s-1];
      end
    end
    // output stage
    resp_data <= stg_data_q[NB_STAGES-1];
    resp_opc  <= stg_err_q[NB_STAGES-1];  // opc reports the range error
    resp_id   <= stg_id_q[NB_STAGES-1];
  end

endmodule : tcdm_resp_scheduler

`default_nettype wire

// File: source/tcdm_ooo_top.sv
// ******************************
// tcdm ooo top: mux, bank and response scheduler
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_top #(
  parameter int unsigned NB_CHAN  = tcdm_ooo_pkg::DEFAULT_NB_CHAN,
  parameter int unsigned DW       = tcdm_ooo_pkg::DEFAULT_DW,
  parameter int unsigned AW       = tcdm_ooo_pkg::DEFAULT_AW,
  parameter int unsigned NB_WORDS = tcdm_ooo_pkg::DEFAULT_NB_WORDS,
  // derived, not meant to be overridden
  parameter int unsigned IW       = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear,
  input  logic                            priority_force,
  input  logic [NB_CHAN-1:0][IW-1:0]      priority_list,
  input  logic [NB_CHAN-1:0]              in_req,
  input  logic [NB_CHAN-1:0][AW-1:0]      in_add,
  input  logic [NB_CHAN-1:0]              in_wen,
  input  logic [NB_CHAN-1:0][DW-1:0]      in_data,
  input  logic [NB_CHAN-1:0][DW/8-1:0]    in_be,
  output logic [NB_CHAN-1:0]              in_gnt,
  output logic [NB_CHAN-1:0]              in_r_valid,
  output logic [NB_CHAN-1:0][DW-1:0]      in_r_data,
  output logic [NB_CHAN-1:0]              in_r_opc
);

  // mux <-> bank / scheduler
  logic            mem_req, mem_gnt, mem_wen;
  logic [AW-1:0]   mem_add;
  logic [DW-1:0]   mem_data;
  logic [DW/8-1:0] mem_be;
  logic [IW-1:0]   mem_id;
  logic            resp_valid, resp_opc;
  logic [DW-1:0]   resp_data;
  logic [IW-1:0]   resp_id;

  // bank -> scheduler
  logic                     acc_valid, acc_err;
  tcdm_ooo_pkg::mem_op_e    acc_op;
  tcdm_ooo_pkg::lat_class_e acc_lat;  // also fed back as mem_add_slow
  logic [DW-1:0]            acc_data;
  logic [IW-1:0]            acc_id;

  tcdm_ooo_mux #(.NB_CHAN(NB_CHAN), .DW(DW), .AW(AW)) i_mux (
    .clk_i, .rst_ni, .clear, .priority_force, .priority_list,
    .in_req, .in_gnt, .in_add, .in_wen, .in_data, .in_be,
    .in_r_valid, .in_r_data, .in_r_opc,
    .mem_req, .mem_gnt, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_id,
    .resp_valid, .resp_data, .resp_opc, .resp_id
  );

  tcdm_mem_bank #(.DW(DW), .AW(AW), .NB_WORDS(NB_WORDS), .NB_CHAN(NB_CHAN)) i_bank (
    .clk_i, .rst_ni,
    .mem_req, .mem_gnt, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_id,
    .acc_valid, .acc_op, .acc_lat, .acc_data, .acc_err, .acc_id
  );

  tcdm_resp_scheduler #(.DW(DW), .NB_CHAN(NB_CHAN)) i_sched (
    .clk_i, .rst_ni,
    .mem_req, .mem_add_slow (acc_lat), .mem_gnt,
    .acc_valid, .acc_op, .acc_lat, .acc_data, .acc_err, .acc_id,
    .resp_valid, .resp_data, .resp_opc, .resp_id
  );

endmodule : tcdm_ooo_top

`default_nettype wire

// File: sim/tcdm_ooo_tb.sv
// ******************************
// tcdm ooo testbench: random traffic checked
// against a model of arbiter, bank and delay line
// ******************************

`timescale 1ns/100ps
`default_nettype none

module tcdm_ooo_tb;

  localparam int N       = 4;
  localparam int DW      = 32;
  localparam int AW      = 12;
  localparam int NW      = 512;
  localparam int IW      = 2;
  localparam int PERIOD  = 100;
  localparam int TMO     = 400;  // cycle budget of a single wait
  localparam int FAST_RD = 0;    // traffic kinds
  localparam int MIXED   = 1;
  localparam int ERRS    = 2;

  // one outstanding response as the model predicts it
  typedef struct packed {
    logic [31:0]   due;     // step index that samples the r_valid pulse
    logic [31:0]   gnt_at;  // grant edge
    logic [IW-1:0] ch;
    logic [DW-1:0] data;
    logic          err;
  } exp_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   clear;
  logic                   priority_force;
  logic [N-1:0][IW-1:0]   priority_list;
  logic [N-1:0]           in_req;
  logic [N-1:0][AW-1:0]   in_add;
  logic [N-1:0]           in_wen;
  logic [N-1:0][DW-1:0]   in_data;
  logic [N-1:0][DW/8-1:0] in_be;
  logic [N-1:0]           in_gnt;
  logic [N-1:0]           in_r_valid;
  logic [N-1:0][DW-1:0]   in_r_data;
  logic [N-1:0]           in_r_opc;

  // per-channel request slots, held until the model sees the grant
  logic [N-1:0]           pend;
  logic [N-1:0][AW-1:0]   pend_add;
  logic [N-1:0]           pend_wen;
  logic [N-1:0][DW-1:0]   pend_data;
  logic [N-1:0][DW/8-1:0] pend_be;
  logic                   clr_nxt;
  logic                   frc_nxt;
  logic [N-1:0][IW-1:0]   lst_nxt;

  logic [DW-1:0] shadow [NW];  // reference memory
  exp_t          exp_q [$];
  int            rr;           // model round-robin counter
  int            edge_no;
  logic          slow_d1;      // slow grant one edge back
  logic          slow_d2;      // and two edges back, i.e. stage 1 busy now
  int            n_grants;
  int            n_overtakes;
  int            t_checks;
  int            t_errs;
  int            all_checks;
  int            all_errs;
  bit            timed_out;
  string         test_name;

  initial clk_i = 1'b0;
  always #(PERIOD/2) clk_i = ~clk_i;

  tcdm_ooo_top #(.NB_CHAN(N), .DW(DW), .AW(AW), .NB_WORDS(NW)) UUT (
    .clk_i, .rst_ni, .clear, .priority_force, .priority_list,
    .in_req, .in_add, .in_wen, .in_data, .in_be,
    .in_gnt, .in_r_valid, .in_r_data, .in_r_opc
  );

  // channel holding rank r, rank 0 first
  function automatic int chan_at_rank(int r);
    if (priority_force)
      return int'(priority_list[r]);
    return (rr + r) % N;
  endfunction

  task automatic check_val(string what, logic [DW-1:0] exp, logic [DW-1:0] act);
    t_checks++;
    if (exp !== act) begin
      t_errs++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_fail(string msg);
    t_errs++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  task automatic timeout(string what);
    if (!timed_out) begin
      t_errs++;
      $display("ERROR %s: timed out waiting for %s", test_name, what);
    end
    timed_out = 1'b1;  // every later wait falls straight through
  endtask

  task automatic load(int ch, int idx, logic wen, logic [DW-1:0] data, logic [DW/8-1:0] be);
    pend[ch]      = 1'b1;
    pend_add[ch]  = AW'(idx * (DW/8));  // word index to byte address
    pend_wen[ch]  = wen;
    pend_data[ch] = data;
    pend_be[ch]   = be;
  endtask

  // one clock: drive on the falling edge, sample a quarter period later
  task automatic step();
    int           win;
    int           idx;
    int           hit;
    logic         slow;
    logic [N-1:0] exp_gnt;
    logic [N-1:0] exp_rv;
    exp_t         e;
    if (timed_out)
      return;
    @(negedge clk_i);
    in_req         = pend;
    in_add         = pend_add;
    in_wen         = pend_wen;
    in_data        = pend_data;
    in_be          = pend_be;
    clear          = clr_nxt;
    priority_force = frc_nxt;
    priority_list  = lst_nxt;
    #(PERIOD/4);
    win = rr;  // nobody requesting
    for (int r = N-1; r >= 0; r--)
      if (pend[chan_at_rank(r)])
        win = chan_at_rank(r);
    idx  = int'(pend_add[win]) / (DW/8);
    slow = (idx >= NW/2);
    exp_gnt = '0;
    if (pend[win] && (slow || !slow_d2))  // a fast access must not land on a busy stage
      exp_gnt[win] = 1'b1;
    check_val("gnt", 32'(exp_gnt), 32'(in_gnt));
    exp_rv = '0;
    hit = -1;
    foreach (exp_q[i])
      if (exp_q[i].due == 32'(edge_no))
        hit = i;
    if (hit >= 0) begin
      e = exp_q[hit];
      exp_q.delete(hit);
      exp_rv[e.ch] = 1'b1;
      foreach (exp_q[i])
        if (exp_q[i].gnt_at < e.gnt_at)
          n_overtakes++;  // an older access is still in flight
      check_val("r_data", e.data, in_r_data[e.ch]);
      check_val("r_opc", 32'(e.err), 32'(in_r_opc[e.ch]));
    end
    check_val("r_valid", 32'(exp_rv), 32'(in_r_valid));
    if (exp_gnt[win]) begin
      e.due    = 32'(edge_no + 1 +
                     int'(slow ? tcdm_ooo_pkg::SLOW_LAT : tcdm_ooo_pkg::FAST_LAT));
      e.gnt_at = 32'(edge_no);
      e.ch     = IW'(win);
      e.err    = (idx >= NW);
      e.data   = '0;  // writes and errors answer zero
      if (!e.err && pend_wen[win])
        e.data = shadow[idx];
      if (!e.err && !pend_wen[win])
        for (int b = 0; b < DW/8; b++)
          if (pend_be[win][b])
            shadow[idx][8*b +: 8] = pend_data[win][8*b +: 8];
      exp_q.push_back(e);
      pend[win] = 1'b0;
      n_grants++;
    end
    if (clear)
      rr = 0;
    else if (exp_gnt[win])
      rr = (rr + 1) % N;
    slow_d2 = slow_d1;
    slow_d1 = exp_gnt[win] & slow;
    edge_no++;
  endtask

  // give every idle channel a new request (or only some, when sparse)
  task automatic fill_idle(int kind, bit sparse);
    int idx;
    for (int ch = 0; ch < N; ch++) begin
      if (!pend[ch] && (!sparse || $urandom_range(1, 0) == 1)) begin
        case (kind)
          FAST_RD: load(ch, $urandom_range(NW/2-1, 0), 1'b1, '0, '1);
          MIXED:   load(ch, $urandom_range(NW-1, 0), 1'($urandom_range(1, 0)),
                        $urandom, 4'($urandom));
          default: begin
            idx = $urandom_range(7, 0);  // small window so aliased words get read back
            if ($urandom_range(1, 0) == 1)
              load(ch, idx + NW, 1'($urandom_range(1, 0)), $urandom, 4'($urandom));
            else
              load(ch, idx, 1'b1, '0, '1);
          end
        endcase
      end
    end
  endtask

  task automatic run(int grants, int kind, bit sparse);
    int start;
    start = n_grants;
    for (int cyc = 0; cyc < 4*grants + TMO && n_grants - start < grants && !timed_out;
         cyc++) begin
      fill_idle(kind, sparse);
      step();
    end
    if (n_grants - start < grants)
      timeout("random traffic grants");
  endtask

  task automatic wait_grant(int ch);
    for (int cyc = 0; cyc < TMO && pend[ch] && !timed_out; cyc++)
      step();
    if (pend[ch])
      timeout($sformatf("grant on channel %0d", ch));
  endtask

  task automatic finish_test();
    for (int cyc = 0; cyc < TMO && (pend != '0 || exp_q.size() != 0) && !timed_out; cyc++)
      step();
    if (pend != '0 || exp_q.size() != 0)
      timeout("outstanding requests and responses");
    repeat (4) step();  // quiet cycles, a stray or duplicate pulse shows here
    $display("test %-16s %0d checks, %0d errors", test_name, t_checks, t_errs);
    all_checks += t_checks;
    all_errs   += t_errs;
    t_checks = 0;
    t_errs   = 0;
  endtask

  task automatic shuffle_list();
    int            j;
    logic [IW-1:0] tmp;
    for (int i = 0; i < N; i++)
      lst_nxt[i] = IW'(i);
    for (int i = N-1; i > 0; i--) begin
      j = $urandom_range(i, 0);
      tmp = lst_nxt[i];
      lst_nxt[i] = lst_nxt[j];
      lst_nxt[j] = tmp;
    end
  endtask

  initial begin
    int w;
    int s;
    void'($urandom(32'h9b139847));
    rst_ni = 1'b0;
    clear = 1'b0;
    priority_force = 1'b0;
    priority_list = '0;
    in_req = '0;
    in_add = '0;
    in_wen = '0;
    in_data = '0;
    in_be = '0;
    pend = '0;
    pend_add = '0;
    pend_wen = '0;
    pend_data = '0;
    pend_be = '0;
    clr_nxt = 1'b0;
    frc_nxt = 1'b0;
    lst_nxt = '0;
    slow_d1 = 1'b0;
    slow_d2 = 1'b0;
    timed_out = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "mem_fill";  // every word written before anything reads it
    w = 0;
    for (int cyc = 0; cyc < 4*NW && w < NW && !timed_out; cyc++) begin
      for (int ch = 0; ch < N; ch++)
        if (!pend[ch] && w < NW) begin
          load(ch, w, 1'b0, DW'(w) * 32'h9e3779b1, '1);
          w++;
        end
      step();
    end
    if (w < NW)
      timeout("memory fill");
    finish_test();

    test_name = "round_robin";
    run(40, FAST_RD, 1'b0);
    run(40, FAST_RD, 1'b1);  // idle cycles must not move the counter
    finish_test();

    test_name = "forced_priority";
    frc_nxt = 1'b1;
    for (int k = 0; k < 4; k++) begin
      shuffle_list();
      run(10, FAST_RD, 1'b1);
    end
    frc_nxt = 1'b0;
    finish_test();

    test_name = "clear_restart";
    if (rr == 0) begin
      load(0, 0, 1'b1, '0, '1);  // move the counter off zero so the clear shows
      wait_grant(0);
    end
    clr_nxt = 1'b1;
    step();
    clr_nxt = 1'b0;
    for (int ch = 0; ch < N; ch++)
      load(ch, ch, 1'b1, '0, '1);
    step();
    check_val("gnt after clear", 32'h1, 32'(in_gnt));  // channel 0 first again
    finish_test();

    test_name = "data_integrity";
    run(200, MIXED, 1'b0);
    finish_test();

    test_name = "out_of_order";
    s = n_overtakes;
    run(120, MIXED, 1'b1);
    if (n_overtakes == s)
      report_fail("no fast response overtook an earlier slow one");
    finish_test();

    test_name = "back_pressure";
    load(0, NW-1, 1'b1, '0, '1);  // slow read
    wait_grant(0);
    step();
    load(1, 0, 1'b1, '0, '1);     // fast read two edges behind it
    step();
    check_val("gnt while stage 1 busy", 32'h0, 32'(in_gnt));
    wait_grant(1);
    run(150, MIXED, 1'b0);
    finish_test();

    test_name = "error_flag";
    run(80, ERRS, 1'b0);
    finish_test();

    $display("total: %0d checks, %0d errors%s", all_checks, all_errs,
             timed_out ? ", run cut short by a timeout" : "");
    if (all_errs == 0 && !timed_out)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule : tcdm_ooo_tb

`default_nettype wire

// File: tcdm_ooo.f
source/tcdm_ooo_pkg.sv
source/tcdm_ooo_mux.sv
source/tcdm_mem_bank.sv
source/tcdm_resp_scheduler.sv
source/tcdm_ooo_top.sv
sim/tcdm_ooo_tb.sv

// File: Makefile
# Verilator build and run of the tcdm ooo testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tcdm_ooo_tb
FILELIST  := tcdm_ooo.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
